// File: compile.f
verilog/invader_pkg.sv
verilog/game_fsm.sv
verilog/player_unit.sv
verilog/alien_unit.sv
verilog/shot_unit.sv
verilog/move_timer.sv
verilog/pixel_mux.sv
verilog/invader_top.sv
testbench/invader_chk.sv
testbench/invader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the game engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
  --top-module invader_tb -o invader_sim

# The simulator exits non-zero on a fatal check, the log decides
./obj_dir/invader_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  exit 1
fi
exit 0

// File: testbench/invader_tb.sv
// Game engine testbench
`timescale 1ns/100ps

module invader_tb;
  import invader_pkg::*;

  localparam logic [23:0] MOVE_DIV = 24'd64;
  localparam int FRAMES = 12;
  localparam logic [31:0] SEED = 32'h828b_93af;
  localparam int LIMIT = FRAMES * (19200 + MOVE_DIV + 20) + 2000; // Cycles

  logic clk, rst, start, btn_left, btn_right, btn_fire;
  logic plot, in_game;
  coord_x_t x;
  coord_y_t y;
  colour_t colour;

  // Frame model state
  coord_x_t m_player_x, m_alien_x, m_shot_x;
  coord_y_t m_alien_y, m_shot_y;
  logic m_dir_right, m_shot_flying;

  invader_top #(.move_div(MOVE_DIV)) UUT (
    .clk(clk), .rst(rst), .start(start), .btn_left(btn_left),
    .btn_right(btn_right), .btn_fire(btn_fire), .plot(plot), .x(x), .y(y),
    .colour(colour), .in_game(in_game)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_fail();
    $display("=== FAIL ===");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_x(coord_x_t got, coord_x_t exp, string name);
    if (got !== exp) begin
      $display("mismatch t=%0t %s got %0d exp %0d", $time, name, got, exp);
      report_fail();
    end
  endtask

  task automatic check_y(coord_y_t got, coord_y_t exp, string name);
    if (got !== exp) begin
      $display("mismatch t=%0t %s got %0d exp %0d", $time, name, got, exp);
      report_fail();
    end
  endtask

  task automatic check_colour(colour_t got, colour_t exp, string name);
    if (got !== exp) begin
      $display("mismatch t=%0t %s got %b exp %b", $time, name, got, exp);
      report_fail();
    end
  endtask

  task automatic check_flag(logic got, logic exp, string name);
    if (got !== exp) begin
      $display("mismatch t=%0t %s got %b exp %b", $time, name, got, exp);
      report_fail();
    end
  endtask

  // Sample on the falling edge until the next pixel write
  task automatic wait_write();
    do @(negedge clk); while (plot !== 1'b1);
  endtask

  task automatic model_update();
    // Shot launches from the column held before this move
    if (m_shot_flying && m_shot_y == 7'd0) begin
      m_shot_flying = 1'b0;
    end else if (m_shot_flying) begin
      m_shot_y = m_shot_y - 7'd1;
    end else if (btn_fire) begin
      m_shot_flying = 1'b1;
      m_shot_x = m_player_x;
      m_shot_y = 7'd111;
    end
    if (btn_left && !btn_right && m_player_x > 8'd0) begin
      m_player_x = m_player_x - 8'd1;
    end else if (btn_right && !btn_left && m_player_x < 8'd159) begin
      m_player_x = m_player_x + 8'd1;
    end
    if (m_dir_right ? (m_alien_x == 8'd150) : (m_alien_x == 8'd50)) begin
      m_dir_right = !m_dir_right;
      m_alien_y = m_alien_y + 7'd1;
    end else begin
      m_alien_x = m_dir_right ? m_alien_x + 8'd1 : m_alien_x - 8'd1;
    end
  endtask

  initial begin
    #(LIMIT * 10);
    $display("watchdog expired, the game stopped producing writes");
    $display("=== FAIL ===");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(SEED));
    rst = 1'b1;
    start = 1'b0;
    btn_left = 1'b0;
    btn_right = 1'b0;
    btn_fire = 1'b0;
    m_player_x = 8'd68;
    m_alien_x = 8'd50;
    m_alien_y = 7'd15;
    m_dir_right = 1'b1;
    m_shot_flying = 1'b0;
    m_shot_x = 8'd68;
    m_shot_y = 7'd111;
    repeat (16) @(posedge clk);
    @(negedge clk) rst = 1'b0;
    repeat (20) begin // Idle until start
      @(negedge clk);
      check_flag(in_game, 1'b0, "in_game");
      check_flag(plot, 1'b0, "plot");
    end
    start = 1'b1;
    @(negedge clk);
    @(negedge clk);
    check_flag(in_game, 1'b1, "in_game");
    start = 1'b0;
    for (int f = 0; f < FRAMES; f++) begin
      wait_write();
      check_colour(colour, 3'b010, "colour");
      check_x(x, m_player_x, "player x");
      check_y(y, 7'd111, "player y");
      {btn_fire, btn_right, btn_left} = 3'($urandom); // Held through the update
      wait_write();
      check_colour(colour, 3'b100, "colour");
      check_x(x, m_alien_x, "alien x");
      check_y(y, m_alien_y, "alien y");
      if (m_shot_flying) begin
        wait_write();
        check_colour(colour, 3'b111, "colour");
        check_x(x, m_shot_x, "shot x");
        check_y(y, m_shot_y, "shot y");
      end
      for (int r = 0; r < 120; r++) begin
        for (int c = 0; c < 160; c++) begin
          wait_write();
          check_colour(colour, 3'b000, "clear colour");
          check_x(x, coord_x_t'(c), "clear x");
          check_y(y, coord_y_t'(r), "clear y");
        end
      end
      model_update();
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: testbench/invader_chk.sv
// Pixel port assertions
`timescale 1ns/100ps

module invader_chk (
  input logic                  clk,
  input logic                  rst,
  input logic                  plot,
  input logic                  in_game,
  input logic                  clear_en,
  input invader_pkg::coord_x_t x,
  input invader_pkg::coord_y_t y,
  input invader_pkg::colour_t  colour
);
  import invader_pkg::*;

  // No writes outside a game
  plot_in_game: assert property (
    @(posedge clk) disable iff (rst) plot |-> in_game
  ) else $error("plot high while in_game low");

  x_in_range: assert property (
    @(posedge clk) disable iff (rst) plot |-> (x < coord_x_t'(SCREEN_W))
  ) else $error("x off screen");

  y_in_range: assert property (
    @(posedge clk) disable iff (rst) plot |-> (y < coord_y_t'(SCREEN_H))
  ) else $error("y off screen");

  // Clear writes trail clear_en by one cycle
  clear_black: assert property (
    @(posedge clk) disable iff (rst) (plot && $past(clear_en)) |-> (colour == COL_BLANK)
  ) else $error("non-black write during clear");

endmodule

bind invader_top invader_chk u_chk (
  .clk(clk), .rst(rst), .plot(plot), .in_game(in_game),
  .clear_en(clear_en), .x(x), .y(y), .colour(colour)
);

// File: verilog/invader_top.sv
// Space shooter game engine top
`timescale 1ns/100ps

module invader_top #(
  parameter logic [23:0] move_div = invader_pkg::MOVE_DIV_DEFAULT
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  btn_left,
  input  logic                  btn_right,
  input  logic                  btn_fire,
  output logic                  plot,
  output invader_pkg::coord_x_t x,
  output invader_pkg::coord_y_t y,
  output invader_pkg::colour_t  colour,
  output logic                  in_game
);
  import invader_pkg::*;

  logic     draw_player, draw_alien, draw_shot;
  logic     restart_timer, clear_en, update;
  logic     shot_flying, next_move, clear_done;
  logic     load_units;
  coord_x_t player_x, alien_x, shot_x;
  coord_y_t alien_y, shot_y;

  assign load_units = !in_game; // Units sit at their start spots until play begins

  game_fsm u_fsm (
    .clk(clk), .rst(rst), .start(start),
    .shot_flying(shot_flying), .next_move(next_move), .clear_done(clear_done),
    .in_game(in_game), .draw_player(draw_player), .draw_alien(draw_alien),
    .draw_shot(draw_shot), .restart_timer(restart_timer), .clear_en(clear_en),
    .update(update)
  );

  player_unit u_player (
    .clk(clk), .rst(rst), .load(load_units), .update(update),
    .btn_left(btn_left), .btn_right(btn_right), .player_x(player_x)
  );

  alien_unit u_alien (
    .clk(clk), .rst(rst), .load(load_units), .update(update),
    .alien_x(alien_x), .alien_y(alien_y)
  );

  shot_unit u_shot (
    .clk(clk), .rst(rst), .load(load_units), .update(update),
    .btn_fire(btn_fire), .player_x(player_x),
    .shot_flying(shot_flying), .shot_x(shot_x), .shot_y(shot_y)
  );

  move_timer #(.move_div(move_div)) u_timer (
    .clk(clk), .rst(rst), .restart(restart_timer), .run(in_game),
    .next_move(next_move)
  );

  pixel_mux u_pixel (
    .clk(clk), .rst(rst),
    .draw_player(draw_player), .draw_alien(draw_alien),
    .draw_shot(draw_shot), .clear_en(clear_en),
    .player_x(player_x), .alien_x(alien_x), .shot_x(shot_x),
    .alien_y(alien_y), .shot_y(shot_y),
    .plot(plot), .x(x), .y(y), .colour(colour), .clear_done(clear_done)
  );

endmodule

// File: verilog/pixel_mux.sv
// Pixel write stage and clear scanner
`timescale 1ns/100ps

module pixel_mux (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  draw_player,
  input  logic                  draw_alien,
  input  logic                  draw_shot,
  input  logic                  clear_en,
  input  invader_pkg::coord_x_t player_x,
  input  invader_pkg::coord_x_t alien_x,
  input  invader_pkg::coord_x_t shot_x,
  input  invader_pkg::coord_y_t alien_y,
  input  invader_pkg::coord_y_t shot_y,
  output logic                  plot,
  output invader_pkg::coord_x_t x,
  output invader_pkg::coord_y_t y,
  output invader_pkg::colour_t  colour,
  output logic                  clear_done
);
  import invader_pkg::*;

  localparam coord_x_t CLR_X_LAST = coord_x_t'(SCREEN_W - 1);
  localparam coord_y_t CLR_Y_LAST = coord_y_t'(SCREEN_H - 1);

  coord_x_t clr_x;
  coord_y_t clr_y;
  logic     clr_x_last;
  logic     clr_y_last;

  assign clr_x_last = (clr_x == CLR_X_LAST);
  assign clr_y_last = (clr_y == CLR_Y_LAST);
  assign clear_done = clear_en && clr_x_last && clr_y_last; // Bottom right pixel

  // Raster scan with x fastest, wraps for the next frame
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      clr_x <= '0;
      clr_y <= '0;
    end else if (clear_en) begin
      if (clr_x_last) begin
        clr_x <= '0;
        clr_y <= clr_y_last ? '0 : clr_y + 7'd1;
      end else begin
        clr_x <= clr_x + 8'd1;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      plot <= 1'b0;
    end else begin
      plot <= draw_player || draw_alien || draw_shot || clear_en;
    end
  end

  // Pixel payload follows the active step
  always_ff @(posedge clk) begin
    if (draw_player) begin
      x      <= player_x;
      y      <= PLAYER_Y;
      colour <= COL_PLAYER;
    end else if (draw_alien) begin
      x      <= alien_x;
      y      <= alien_y;
      colour <= COL_ALIEN;
    end else if (draw_shot) begin
      x      <= shot_x;
      y      <= shot_y;
      colour <= COL_SHOT;
    end else if (clear_en) begin
      x      <= clr_x;
      y      <= clr_y;
      colour <= COL_BLANK;
    end
  end

endmodule

// File: verilog/move_timer.sv
// Game pace timer
`timescale 1ns/100ps

module move_timer #(
  parameter logic [23:0] move_div = invader_pkg::MOVE_DIV_DEFAULT
) (
  input  logic clk,
  input  logic rst,
  input  logic restart,
  input  logic run,
  output logic next_move
);

  logic [23:0] count;
  logic        armed; // Cleared once the tick has gone out

  // Tick lands move_div cycles after the restart cycle
  assign next_move = armed && run && (count == move_div - 24'd1);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
      armed <= 1'b0;
    end else if (restart) begin
      count <= '0;
      armed <= 1'b1;
    end else if (next_move) begin
      armed <= 1'b0;
    end else if (run && armed) begin
      count <= count + 24'd1;
    end
  end

endmodule

// File: verilog/shot_unit.sv
// Player shot
`timescale 1ns/100ps

module shot_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load,
  input  logic                 update,
  input  logic                 btn_fire,
  input  invader_pkg::coord_x_t player_x,
  output logic                 shot_flying,
  output invader_pkg::coord_x_t shot_x,
  output invader_pkg::coord_y_t shot_y
);
  import invader_pkg::*;

  logic at_top;

  assign at_top = (shot_y == '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      shot_flying <= 1'b0;
      shot_x      <= PLAYER_X0;
      shot_y      <= PLAYER_Y;
    end else if (load) begin
      shot_flying <= 1'b0;
      shot_x      <= PLAYER_X0;
      shot_y      <= PLAYER_Y;
    end else if (update) begin
      if (shot_flying && at_top) begin
        shot_flying <= 1'b0; // Left the screen
      end else if (shot_flying) begin
        shot_y <= shot_y - 7'd1;
      end else if (btn_fire) begin
        // player_x still holds the column before this update's move
        shot_flying <= 1'b1;
        shot_x      <= player_x;
        shot_y      <= PLAYER_Y;
      end
    end
  end

endmodule

// File: verilog/alien_unit.sv
// Alien sweep
`timescale 1ns/100ps

module alien_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load,
  input  logic                 update,
  output invader_pkg::coord_x_t alien_x,
  output invader_pkg::coord_y_t alien_y
);
  import invader_pkg::*;

  logic dir_right; // Current sweep direction
  logic at_bound;

  assign at_bound = dir_right ? (alien_x == ALIEN_X_MAX) : (alien_x == ALIEN_X_MIN);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      alien_x   <= ALIEN_X0;
      alien_y   <= ALIEN_Y0;
      dir_right <= 1'b1;
    end else if (load) begin
      alien_x   <= ALIEN_X0;
      alien_y   <= ALIEN_Y0;
      dir_right <= 1'b1;
    end else if (update) begin
      if (at_bound) begin
        // Turn around and drop a row, x holds this step
        dir_right <= !dir_right;
        alien_y   <= alien_y + 7'd1;
      end else if (dir_right) begin
        alien_x <= alien_x + 8'd1;
      end else begin
        alien_x <= alien_x - 8'd1;
      end
    end
  end

endmodule

// File: verilog/player_unit.sv
// Player cannon
`timescale 1ns/100ps

module player_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load,
  input  logic                 update,
  input  logic                 btn_left,
  input  logic                 btn_right,
  output invader_pkg::coord_x_t player_x
);
  import invader_pkg::*;

  localparam coord_x_t X_LAST = coord_x_t'(SCREEN_W - 1);

  logic move_left;
  logic move_right;

  // Both buttons held means stay put
  assign move_left  = btn_left && !btn_right && (player_x != '0);
  assign move_right = btn_right && !btn_left && (player_x < X_LAST);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      player_x <= PLAYER_X0;
    end else if (load) begin
      player_x <= PLAYER_X0;
    end else if (update) begin
      if (move_left) begin
        player_x <= player_x - 8'd1;
      end else if (move_right) begin
        player_x <= player_x + 8'd1;
      end
    end
  end

endmodule

// File: verilog/game_fsm.sv
// Frame sequencer
`timescale 1ns/100ps

module game_fsm (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic shot_flying,
  input  logic next_move,
  input  logic clear_done,
  output logic in_game,
  output logic draw_player,
  output logic draw_alien,
  output logic draw_shot,
  output logic restart_timer,
  output logic clear_en,
  output logic update
);
  import invader_pkg::*;

  game_state_t state;
  game_state_t state_nxt;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Every sprite is a single pixel, so draw steps never stall
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        state_nxt = start ? ST_START : ST_IDLE;
      end
      ST_START:        state_nxt = ST_DRAW_PLAYER;
      ST_DRAW_PLAYER:  state_nxt = ST_DRAW_ALIEN;
      ST_DRAW_ALIEN:   state_nxt = ST_CHECK_SHOT;
      ST_CHECK_SHOT: begin
        state_nxt = shot_flying ? ST_DRAW_SHOT : ST_RESTART_WAIT;
      end
      ST_DRAW_SHOT:    state_nxt = ST_RESTART_WAIT;
      ST_RESTART_WAIT: state_nxt = ST_WAIT_MOVE;
      ST_WAIT_MOVE: begin
        state_nxt = next_move ? ST_CLEAR : ST_WAIT_MOVE; // Hold until pace tick
      end
      ST_CLEAR: begin
        state_nxt = clear_done ? ST_UPDATE : ST_CLEAR;
      end
      ST_UPDATE:       state_nxt = ST_DRAW_PLAYER;
      default:         state_nxt = ST_IDLE;
    endcase
  end

  // Step strobes decoded from the state register
  assign in_game     = (state != ST_IDLE);
  assign draw_player = (state == ST_DRAW_PLAYER);
  assign draw_alien  = (state == ST_DRAW_ALIEN);
  assign draw_shot   = (state == ST_DRAW_SHOT);
  assign clear_en    = (state == ST_CLEAR);
  assign update      = (state == ST_UPDATE);

  // Timer restarts at game start and once per frame
  assign restart_timer = (state == ST_START) || (state == ST_RESTART_WAIT);

endmodule

// File: verilog/invader_pkg.sv
// Space shooter game engine
// Shared types and constants
package invader_pkg;

  typedef logic [7:0] coord_x_t;
  typedef logic [6:0] coord_y_t;
  typedef logic [2:0] colour_t; // {r, g, b}

  typedef enum logic [3:0] {
    ST_IDLE         = 4'd0,
    ST_START        = 4'd1,
    ST_DRAW_PLAYER  = 4'd2,
    ST_DRAW_ALIEN   = 4'd3,
    ST_CHECK_SHOT   = 4'd4,
    ST_DRAW_SHOT    = 4'd5,
    ST_RESTART_WAIT = 4'd6,
    ST_WAIT_MOVE    = 4'd7,
    ST_CLEAR        = 4'd8,
    ST_UPDATE       = 4'd9
  } game_state_t;

  // Frame buffer geometry
  localparam int unsigned SCREEN_W = 160;
  localparam int unsigned SCREEN_H = 120;

  localparam coord_x_t PLAYER_X0 = 8'd68;
  localparam coord_y_t PLAYER_Y  = 7'd111; // Cannon row, shot starts here too

  // Alien sweep range
  localparam coord_x_t ALIEN_X0    = 8'd50;
  localparam coord_y_t ALIEN_Y0    = 7'd15;
  localparam coord_x_t ALIEN_X_MIN = 8'd50;
  localparam coord_x_t ALIEN_X_MAX = 8'd150;

  localparam colour_t COL_PLAYER = 3'b010; // Green
  localparam colour_t COL_ALIEN  = 3'b100; // Red
  localparam colour_t COL_SHOT   = 3'b111; // White
  localparam colour_t COL_BLANK  = 3'b000; // Black

  // Roughly 60 moves per second at 50 MHz
  localparam logic [23:0] MOVE_DIV_DEFAULT = 24'd833333;

endpackage
